// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert --timing -Wno-fatal
TOP      = tb_vdp
FILELIST = msx_vdp.f
PASS_MSG = Testbench passed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: msx_vdp.f
src/vdp_pkg.sv
src/vram_sp.sv
src/vram_arbiter.sv
src/vdp_video_timing.sv
src/vdp_pixel_fetch.sv
src/vdp_cpu_port.sv
src/vdp_top.sv
sim/tb_vdp.sv

// File: sim/tb_vdp.sv
`timescale 1ns/1ps

module tb_vdp import vdp_pkg::*; ();

    localparam logic [7:0]  base_port    = 8'h98;
    localparam logic [7:0]  a_data       = {base_port[7:2], port_data};
    localparam logic [7:0]  a_ctrl       = {base_port[7:2], port_ctrl};
    localparam logic [7:0]  a_pal        = {base_port[7:2], port_pal};
    localparam int          frame_cycles = int'(h_total) * int'(v_total) * pix_div;
    localparam logic [31:0] lfsr_taps    = 32'h80200003;
    localparam logic [vram_aw-1:0] test_base = 15'h6000; // Outside the bitmap

    logic cpu_bus = 1'b0;
    logic rst_n, iorq, m1, wr, req, dev_enable;
    logic [7:0] io_addr, io_wdata, io_port, io_mask, io_rdata;
    logic [7:0] r, g, b;
    logic interrupt, hs, vs, de, hblank, vblank, ce_pix;

    logic [31:0]        lfsr = 32'h10b37a48;
    logic [7:0]         ref_mem [0:vram_words-1];
    logic [pal_w-1:0]   pal_model [0:pal_entries-1];
    logic [vram_aw-1:0] vptr;
    logic [7:0]         rd_exp; // Model of the read-ahead buffer
    int checks = 0;
    int errors = 0;
    int test_start = 0;

    vdp_top UUT (.*);

    always #2 cpu_bus = ~cpu_bus;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    function automatic logic [7:0] expand_channel(input logic [2:0] c);
        logic [8:0] rep;
        rep = {3{c}};
        return rep[8:1];
    endfunction

    task automatic rand_bits(input int n, output logic [8:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[7:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        errors++;
        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, got);
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else report_mismatch(name, exp, got);
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, errors - test_start);
        test_start = errors;
    endtask

    task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
        @(posedge cpu_bus);
        iorq     <= 1'b1;
        wr       <= 1'b1;
        req      <= 1'b1;
        io_addr  <= addr;
        io_wdata <= data;
        @(posedge cpu_bus);
        iorq <= 1'b0;
        wr   <= 1'b0;
        req  <= 1'b0;
        repeat (6) @(posedge cpu_bus);
    endtask

    task automatic io_read(input logic [7:0] addr, output logic [7:0] data);
        @(posedge cpu_bus);
        iorq    <= 1'b1;
        wr      <= 1'b0;
        req     <= 1'b1;
        io_addr <= addr;
        @(negedge cpu_bus);
        data = io_rdata;
        @(posedge cpu_bus);
        iorq <= 1'b0;
        req  <= 1'b0;
        repeat (6) @(posedge cpu_bus);
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [7:0] val);
        io_write(a_ctrl, val);
        io_write(a_ctrl, {3'b100, idx});
    endtask

    // The read-ahead takes the loaded address, so the pointer moves on by one
    task automatic set_vram_addr(input logic [vram_aw-1:0] a);
        io_write(a_ctrl, a[7:0]);
        io_write(a_ctrl, {1'b0, a[14:8]});
        rd_exp = ref_mem[a];
        vptr   = a + 1'b1;
    endtask

    task automatic vram_write(input logic [7:0] d);
        io_write(a_data, d);
        ref_mem[vptr] = d;
        vptr = vptr + 1'b1;
    endtask

    task automatic vram_read_check();
        logic [7:0] d;
        io_read(a_data, d);
        check_val("io_rdata", rd_exp, d);
        rd_exp = ref_mem[vptr];
        vptr   = vptr + 1'b1;
    endtask

    task automatic wait_vs(input logic level);
        int n;
        n = 0;
        while (vs !== level && n < frame_cycles) begin
            @(negedge cpu_bus);
            n++;
        end
        if (vs !== level) begin
            errors++;
            $display("Timeout: vs did not reach %0d within a frame", level);
        end
    endtask

    task automatic wait_interrupt();
        int n;
        n = 0;
        while (interrupt !== 1'b1 && n < frame_cycles) begin
            @(negedge cpu_bus);
            n++;
        end
        if (interrupt !== 1'b1) begin
            errors++;
            $display("Timeout: interrupt did not rise within a frame");
        end
    endtask

    task automatic check_pixel(input logic [pal_w-1:0] p);
        check_val("r", expand_channel(p[8:6]), r);
        check_val("g", expand_channel(p[5:3]), g);
        check_val("b", expand_channel(p[2:0]), b);
    endtask

    // Walks the de pixels of the next frame from line 0
    task automatic scan_frame(input logic bitmap, input int lines);
        int k;
        int n;
        int x;
        int line;
        int hs_px;
        logic [7:0] byte_v;
        k = 0;
        n = 0;
        hs_px = 0;
        wait_vs(1'b1);
        wait_vs(1'b0);
        while (k < lines * int'(h_active) && n < frame_cycles) begin
            @(negedge cpu_bus);
            n++;
            if (ce_pix && hs && !vblank) begin
                hs_px++; // Sync pixels of the visible lines
            end
            if (ce_pix && de) begin
                x    = k % int'(h_active);
                line = k / int'(h_active);
                if (!bitmap) begin
                    check_pixel(pal_model[7]);
                end else if ((line == 0 || line == 5) && x < 16) begin
                    byte_v = ref_mem[line * bytes_per_line + x / 2];
                    check_pixel(pal_model[(x % 2) ? byte_v[3:0] : byte_v[7:4]]);
                end
                k++;
            end
        end
        if (k < lines * int'(h_active)) begin
            errors++;
            $display("Timeout: only %0d display pixels seen in a frame", k);
        end else begin
            check_val("hs pixels", (lines - 1) * int'(hs_end - hs_start), hs_px);
        end
    endtask

    assert property (@(posedge cpu_bus) disable iff (!rst_n)
        !dev_enable |-> ({r, g, b, hs, vs, de, hblank, vblank, ce_pix, interrupt} == '0))
        else report_mismatch("video_out", 64'd0,
                             {r, g, b, hs, vs, de, hblank, vblank, ce_pix, interrupt});

    assert property (@(posedge cpu_bus) disable iff (!rst_n)
        (dev_enable && ce_pix && !vblank) |-> (hblank == !de))
        else report_mismatch("hblank", 64'(!de), 64'(hblank));

    initial begin
        logic [7:0] d;
        logic [8:0] v;
        logic       seen;
        rst_n      <= 1'b0;
        iorq       <= 1'b0;
        m1         <= 1'b0;
        wr         <= 1'b0;
        req        <= 1'b0;
        dev_enable <= 1'b1;
        io_addr    <= 8'h00;
        io_wdata   <= 8'h00;
        io_port    <= base_port;
        io_mask    <= 8'hfc;
        repeat (16) @(posedge cpu_bus);
        rst_n <= 1'b1;

        @(negedge cpu_bus);
        check_val("interrupt", 0, interrupt);
        check_val("de", 0, de);
        check_val("hs", 0, hs);
        check_val("vs", 0, vs);
        io_read(8'h10, d);
        check_val("io_rdata", 8'hff, d);
        @(posedge cpu_bus);
        dev_enable <= 1'b0;
        io_read(a_ctrl, d);
        check_val("io_rdata", 8'hff, d);
        repeat (2 * int'(h_total) * pix_div) @(posedge cpu_bus); // Two lines of hs
        dev_enable <= 1'b1;
        end_test(1, "reset and selection");

        set_vram_addr(test_base);
        for (int i = 0; i < 64; i++) begin
            rand_bits(8, v);
            vram_write(v[7:0]);
        end
        set_vram_addr(test_base + 1'b1);
        for (int i = 0; i < 64; i++) begin
            vram_read_check();
        end
        end_test(2, "vram write and read-back");

        set_vram_addr('1); // Pointer wraps to line 0
        for (int i = 0; i < 8; i++) begin
            rand_bits(8, v);
            vram_write(v[7:0]);
        end
        set_vram_addr(vram_aw'(5 * bytes_per_line - 1));
        for (int i = 0; i < 8; i++) begin
            rand_bits(8, v);
            vram_write(v[7:0]);
        end
        set_reg(reg_pal_ptr, 8'h00);
        for (int i = 0; i < pal_entries; i++) begin
            rand_bits(pal_w, v);
            pal_model[i] = v;
            io_write(a_pal, {1'b0, v[8:6], 1'b0, v[2:0]});
            io_write(a_pal, {5'd0, v[5:3]});
        end
        set_reg(reg_mode1, 8'h40);
        scan_frame(1'b1, 6);
        end_test(3, "palette and bitmap display");

        set_reg(reg_mode1, 8'h00);
        set_reg(reg_border, 8'h07);
        scan_frame(1'b0, int'(v_active));
        end_test(4, "border and blanking");

        io_read(a_ctrl, d); // Drop a flag left from earlier frames
        set_reg(reg_mode1, 8'h20);
        @(negedge cpu_bus);
        check_val("interrupt", 0, interrupt);
        wait_interrupt();
        @(posedge cpu_bus);
        dev_enable <= 1'b0; // Raised interrupt and vblank border must be gated
        repeat (2 * pix_div) @(posedge cpu_bus);
        dev_enable <= 1'b1;
        io_read(a_ctrl, d);
        check_val("status[7]", 1, d[7]);
        @(negedge cpu_bus);
        check_val("interrupt", 0, interrupt);
        io_read(a_ctrl, d);
        check_val("status[7]", 0, d[7]);
        set_reg(reg_mode1, 8'h00);
        seen = 1'b0;
        repeat (frame_cycles + 1000) begin
            @(negedge cpu_bus);
            seen = seen | interrupt;
        end
        check_val("interrupt", 0, seen);
        end_test(5, "vblank interrupt");

        io_write(a_ctrl, 8'h5a); // Lone first byte
        io_read(a_ctrl, d);
        set_vram_addr(test_base + 15'd10);
        vram_read_check();
        vram_read_check();
        end_test(6, "control latch reset");

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: src/vdp_cpu_port.sv
`timescale 1ns/1ps

module vdp_cpu_port import vdp_pkg::*; (
    input  logic                         cpu_bus,
    input  logic                         rst_n,
    input  logic [7:0]                   io_addr,
    input  logic [7:0]                   io_wdata,
    input  logic                         iorq,
    input  logic                         m1,
    input  logic                         wr,
    input  logic                         req,
    input  logic [7:0]                   io_port,
    input  logic [7:0]                   io_mask,
    output logic [7:0]                   io_rdata,
    input  logic                         vblank_start,
    output logic                         interrupt,
    output logic                         disp_en,
    output logic [pal_aw-1:0]            border_idx,
    output logic [pal_entries*pal_w-1:0] palette_rgb,
    output logic                         cpu_vram_req,
    output logic [vram_aw-1:0]           cpu_vram_addr,
    output logic                         cpu_vram_we,
    output logic [7:0]                   cpu_vram_wdata,
    input  logic                         cpu_vram_gnt,
    input  logic                         cpu_vram_rvalid,
    input  logic [7:0]                   vram_q
);

    logic              sel;
    logic              acc;
    logic              data_wr, data_rd, ctrl_wr, status_rd, pal_wr;
    logic              reg_wr, addr_wr;
    logic              ctrl_pending;
    logic [7:0]        ctrl_byte;
    logic              pal_phase;
    logic [7:0]        pal_byte;
    logic [pal_aw-1:0] pal_ptr;
    logic [pal_w-1:0]  pal_mem [0:pal_entries-1];
    logic              vblank_flag;
    logic              ie;
    logic [7:0]        rd_buf;

    assign sel = iorq && !m1 && ((io_addr & io_mask) == io_port);
    assign acc = sel && req;

    assign data_wr   = acc &&  wr && (io_addr[1:0] == port_data);
    assign data_rd   = acc && !wr && (io_addr[1:0] == port_data);
    assign ctrl_wr   = acc &&  wr && (io_addr[1:0] == port_ctrl);
    assign status_rd = acc && !wr && (io_addr[1:0] == port_ctrl);
    assign pal_wr    = acc &&  wr && (io_addr[1:0] == port_pal);

    // Second control byte, bit 7 picks register or address
    assign reg_wr  = ctrl_wr && ctrl_pending &&  io_wdata[7];
    assign addr_wr = ctrl_wr && ctrl_pending && !io_wdata[7];

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_pending  <= 1'b0;
            vblank_flag   <= 1'b0;
            pal_phase     <= 1'b0;
            pal_ptr       <= '0;
            disp_en       <= 1'b0;
            ie            <= 1'b0;
            border_idx    <= '0;
            cpu_vram_req  <= 1'b0;
            cpu_vram_we   <= 1'b0;
            cpu_vram_addr <= '0;
        end else begin
            if (ctrl_wr) begin
                ctrl_pending <= !ctrl_pending;
            end
            if (status_rd) begin
                ctrl_pending <= 1'b0;
                vblank_flag  <= 1'b0;
            end
            if (vblank_start) begin
                vblank_flag <= 1'b1;
            end

            if (pal_wr) begin
                pal_phase <= !pal_phase;
                if (pal_phase) begin
                    pal_ptr <= pal_ptr + 1'b1;
                end
            end

            if (reg_wr) begin
                case (io_wdata[4:0])
                    reg_mode1: begin
                        disp_en <= ctrl_byte[mode1_disp_bit];
                        ie      <= ctrl_byte[mode1_ie_bit];
                    end
                    reg_border: border_idx <= ctrl_byte[pal_aw-1:0];
                    reg_pal_ptr: begin
                        pal_ptr   <= ctrl_byte[pal_aw-1:0];
                        pal_phase <= 1'b0; // Restart the byte pair
                    end
                    default: ;
                endcase
            end

            if (cpu_vram_gnt) begin
                cpu_vram_req  <= 1'b0;
                cpu_vram_addr <= cpu_vram_addr + 1'b1;
            end
            if (addr_wr) begin
                cpu_vram_addr <= vram_aw'({io_wdata[6:0], ctrl_byte});
                cpu_vram_req  <= 1'b1; // Read-ahead
                cpu_vram_we   <= 1'b0;
            end else if (data_wr) begin
                cpu_vram_req <= 1'b1;
                cpu_vram_we  <= 1'b1;
            end else if (data_rd) begin
                cpu_vram_req <= 1'b1; // Refill after the read
                cpu_vram_we  <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (ctrl_wr && !ctrl_pending) begin
            ctrl_byte <= io_wdata;
        end
        if (pal_wr && !pal_phase) begin
            pal_byte <= io_wdata;
        end
        if (pal_wr && pal_phase) begin
            pal_mem[pal_ptr] <= {pal_byte[6:4], io_wdata[2:0], pal_byte[2:0]};
        end
        if (data_wr) begin
            cpu_vram_wdata <= io_wdata;
        end
        if (cpu_vram_rvalid) begin
            rd_buf <= vram_q;
        end
    end

    always_comb begin
        for (int i = 0; i < pal_entries; i++) begin
            palette_rgb[i*pal_w +: pal_w] = pal_mem[i];
        end
    end

    always_comb begin
        io_rdata = 8'hff;
        if (sel) begin
            case (io_addr[1:0])
                port_data: io_rdata = rd_buf;
                port_ctrl: io_rdata = {vblank_flag, 7'd0};
                default:   io_rdata = 8'hff;
            endcase
        end
    end

    assign interrupt = vblank_flag && ie;

endmodule

// File: src/vdp_pixel_fetch.sv
`timescale 1ns/1ps

module vdp_pixel_fetch import vdp_pkg::*; (
    input  logic                         cpu_bus,
    input  logic                         rst_n,
    input  logic                         pix_ce,
    input  logic [hc_w-1:0]              h_cnt,
    input  logic [vc_w-1:0]              v_cnt,
    input  logic                         h_act,
    input  logic                         v_act,
    input  logic                         hs,
    input  logic                         vs,
    input  logic                         disp_en,
    input  logic [pal_aw-1:0]            border_idx,
    input  logic [pal_entries*pal_w-1:0] palette_rgb,
    output logic                         disp_req,
    output logic [vram_aw-1:0]           disp_addr,
    input  logic                         disp_rvalid,
    input  logic [7:0]                   vram_q,
    output logic [7:0]                   r,
    output logic [7:0]                   g,
    output logic [7:0]                   b,
    output logic                         de,
    output logic                         hblank,
    output logic                         vblank,
    output logic                         hs_o,
    output logic                         vs_o,
    output logic                         ce_pix
);

    logic [7:0]        byte_q;
    logic              st_h0;
    logic              st_h_act;
    logic              st_v_act;
    logic              st_hs;
    logic              st_vs;
    logic [pal_aw-1:0] pix_idx;
    logic [pal_aw-1:0] col_idx;
    logic [pal_w-1:0]  col;

    function automatic logic [7:0] widen3(input logic [2:0] c);
        return {c, c, c[2:1]};
    endfunction

    // One fetch per pixel pair
    assign disp_req  = pix_ce && h_act && v_act && !h_cnt[0];
    assign disp_addr = vram_aw'(v_cnt * bytes_per_line) + vram_aw'(h_cnt >> 1);

    always_ff @(posedge cpu_bus) begin
        if (disp_rvalid) begin
            byte_q <= vram_q;
        end
    end

    // Pixel whose counters were just left
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            st_h0    <= 1'b0;
            st_h_act <= 1'b0;
            st_v_act <= 1'b0;
            st_hs    <= 1'b0;
            st_vs    <= 1'b0;
        end else if (pix_ce) begin
            st_h0    <= h_cnt[0];
            st_h_act <= h_act;
            st_v_act <= v_act;
            st_hs    <= hs;
            st_vs    <= vs;
        end
    end

    always_comb begin
        pix_idx = st_h0 ? byte_q[3:0] : byte_q[7:4]; // High nibble first
        col_idx = (st_h_act && st_v_act && disp_en) ? pix_idx : border_idx;
        col     = palette_rgb[col_idx * pal_w +: pal_w];
    end

    always_ff @(posedge cpu_bus) begin
        if (pix_ce) begin
            r <= widen3(col[8:6]);
            g <= widen3(col[5:3]);
            b <= widen3(col[2:0]);
        end
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            de     <= 1'b0;
            hblank <= 1'b0;
            vblank <= 1'b0;
            hs_o   <= 1'b0;
            vs_o   <= 1'b0;
            ce_pix <= 1'b0;
        end else begin
            ce_pix <= pix_ce;
            if (pix_ce) begin
                de     <= st_h_act && st_v_act;
                hblank <= !st_h_act;
                vblank <= !st_v_act;
                hs_o   <= st_hs;
                vs_o   <= st_vs;
            end
        end
    end

endmodule

// File: src/vdp_pkg.sv
package vdp_pkg;

    // VRAM geometry
    localparam int vram_aw    = 15;
    localparam int vram_words = 2 ** vram_aw;

    // Counter widths
    localparam int hc_w = 9;
    localparam int vc_w = 8;

    // Horizontal timing in pixels
    localparam logic [hc_w-1:0] h_active = 9'd256;
    localparam logic [hc_w-1:0] h_total  = 9'd320;
    localparam logic [hc_w-1:0] hs_start = 9'd280;
    localparam logic [hc_w-1:0] hs_end   = 9'd300;

    // Vertical timing in lines
    localparam logic [vc_w-1:0] v_active = 8'd192;
    localparam logic [vc_w-1:0] v_total  = 8'd220;
    localparam logic [vc_w-1:0] vs_start = 8'd200;
    localparam logic [vc_w-1:0] vs_end   = 8'd203;

    localparam int pix_div        = 4;
    localparam int pdiv_w         = $clog2(pix_div);
    localparam int bytes_per_line = 128;

    // Low address bits of the I/O ports
    localparam logic [1:0] port_data = 2'd0;
    localparam logic [1:0] port_ctrl = 2'd1;
    localparam logic [1:0] port_pal  = 2'd2;

    // Register indices
    localparam logic [4:0] reg_mode1   = 5'd1;
    localparam logic [4:0] reg_border  = 5'd7;
    localparam logic [4:0] reg_pal_ptr = 5'd16;

    localparam int mode1_disp_bit = 6;
    localparam int mode1_ie_bit   = 5;

    // Palette, entries are {r[2:0], g[2:0], b[2:0]}
    localparam int pal_entries = 16;
    localparam int pal_aw      = $clog2(pal_entries);
    localparam int pal_w       = 9;

endpackage

// File: src/vdp_top.sv
`timescale 1ns/1ps

module vdp_top import vdp_pkg::*; (
    input  logic       cpu_bus,
    input  logic       rst_n,
    input  logic [7:0] io_addr,
    input  logic [7:0] io_wdata,
    input  logic       iorq,
    input  logic       m1,
    input  logic       wr,
    input  logic       req,
    input  logic       dev_enable,
    input  logic [7:0] io_port,
    input  logic [7:0] io_mask,
    output logic [7:0] io_rdata,
    output logic       interrupt,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b,
    output logic       hs,
    output logic       vs,
    output logic       de,
    output logic       hblank,
    output logic       vblank,
    output logic       ce_pix
);

    logic [7:0]                   cpu_rdata;
    logic                         cpu_int;
    logic                         disp_en;
    logic [pal_aw-1:0]            border_idx;
    logic [pal_entries*pal_w-1:0] palette_rgb;
    logic                         cpu_vram_req, cpu_vram_we, cpu_vram_gnt, cpu_vram_rvalid;
    logic [vram_aw-1:0]           cpu_vram_addr;
    logic [7:0]                   cpu_vram_wdata;
    logic                         disp_req, disp_rvalid;
    logic [vram_aw-1:0]           disp_addr;
    logic [vram_aw-1:0]           mem_addr;
    logic                         mem_we;
    logic [7:0]                   mem_wdata, vram_q;
    logic                         pix_ce, vblank_start;
    logic [hc_w-1:0]              h_cnt;
    logic [vc_w-1:0]              v_cnt;
    logic                         h_act, v_act, t_hs, t_vs;
    logic [7:0]                   f_r, f_g, f_b;
    logic                         f_de, f_hblank, f_vblank, f_hs, f_vs, f_ce;

    vdp_cpu_port u_cpu_port (
        .cpu_bus, .rst_n, .io_addr, .io_wdata, .iorq, .m1, .wr,
        .req(req & dev_enable), // Disabled device ignores the bus
        .io_port, .io_mask, .io_rdata(cpu_rdata), .vblank_start,
        .interrupt(cpu_int), .disp_en, .border_idx, .palette_rgb,
        .cpu_vram_req, .cpu_vram_addr, .cpu_vram_we, .cpu_vram_wdata,
        .cpu_vram_gnt, .cpu_vram_rvalid, .vram_q
    );

    vdp_video_timing u_timing (
        .cpu_bus, .rst_n, .pix_ce, .h_cnt, .v_cnt, .h_act, .v_act,
        .hs(t_hs), .vs(t_vs), .vblank_start
    );

    vdp_pixel_fetch u_fetch (
        .cpu_bus, .rst_n, .pix_ce, .h_cnt, .v_cnt, .h_act, .v_act,
        .hs(t_hs), .vs(t_vs), .disp_en, .border_idx, .palette_rgb,
        .disp_req, .disp_addr, .disp_rvalid, .vram_q,
        .r(f_r), .g(f_g), .b(f_b), .de(f_de), .hblank(f_hblank),
        .vblank(f_vblank), .hs_o(f_hs), .vs_o(f_vs), .ce_pix(f_ce)
    );

    vram_arbiter u_arbiter (
        .cpu_bus, .rst_n, .disp_req, .disp_addr, .disp_rvalid,
        .cpu_vram_req, .cpu_vram_addr, .cpu_vram_we, .cpu_vram_wdata,
        .cpu_vram_gnt, .cpu_vram_rvalid, .mem_addr, .mem_we, .mem_wdata
    );

    vram_sp u_vram (
        .cpu_bus, .addr(mem_addr), .we(mem_we), .wdata(mem_wdata), .q(vram_q)
    );

    assign r         = dev_enable ? f_r      : '0;
    assign g         = dev_enable ? f_g      : '0;
    assign b         = dev_enable ? f_b      : '0;
    assign hs        = dev_enable ? f_hs     : 1'b0;
    assign vs        = dev_enable ? f_vs     : 1'b0;
    assign de        = dev_enable ? f_de     : 1'b0;
    assign hblank    = dev_enable ? f_hblank : 1'b0;
    assign vblank    = dev_enable ? f_vblank : 1'b0;
    assign ce_pix    = dev_enable ? f_ce     : 1'b0;
    assign interrupt = dev_enable ? cpu_int  : 1'b0;
    assign io_rdata  = dev_enable ? cpu_rdata : 8'hff;

endmodule

// File: src/vdp_video_timing.sv
`timescale 1ns/1ps

module vdp_video_timing import vdp_pkg::*; (
    input  logic            cpu_bus,
    input  logic            rst_n,
    output logic            pix_ce,
    output logic [hc_w-1:0] h_cnt,
    output logic [vc_w-1:0] v_cnt,
    output logic            h_act,
    output logic            v_act,
    output logic            hs,
    output logic            vs,
    output logic            vblank_start
);

    logic [pdiv_w-1:0] div_cnt;
    logic              h_last;
    logic              v_last;

    assign pix_ce = (div_cnt == pdiv_w'(pix_div - 1));
    assign h_last = (h_cnt == h_total - 1'b1);
    assign v_last = (v_cnt == v_total - 1'b1);

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (pix_ce) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (pix_ce) begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign h_act = (h_cnt < h_active);
    assign v_act = (v_cnt < v_active);
    assign hs    = (h_cnt >= hs_start) && (h_cnt < hs_end);
    assign vs    = (v_cnt >= vs_start) && (v_cnt < vs_end);

    // First pixel of the first blanked line
    assign vblank_start = pix_ce && (h_cnt == '0) && (v_cnt == v_active);

endmodule

// File: src/vram_arbiter.sv
`timescale 1ns/1ps

module vram_arbiter import vdp_pkg::*; (
    input  logic               cpu_bus,
    input  logic               rst_n,
    input  logic               disp_req,
    input  logic [vram_aw-1:0] disp_addr,
    output logic               disp_rvalid,
    input  logic               cpu_vram_req,
    input  logic [vram_aw-1:0] cpu_vram_addr,
    input  logic               cpu_vram_we,
    input  logic [7:0]         cpu_vram_wdata,
    output logic               cpu_vram_gnt,
    output logic               cpu_vram_rvalid,
    output logic [vram_aw-1:0] mem_addr,
    output logic               mem_we,
    output logic [7:0]         mem_wdata
);

    // Display always wins, CPU waits a cycle
    assign cpu_vram_gnt = cpu_vram_req & ~disp_req;

    assign mem_addr  = disp_req ? disp_addr : cpu_vram_addr;
    assign mem_we    = cpu_vram_gnt & cpu_vram_we;
    assign mem_wdata = cpu_vram_wdata;

    // Owner of the read in flight
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            disp_rvalid     <= 1'b0;
            cpu_vram_rvalid <= 1'b0;
        end else begin
            disp_rvalid     <= disp_req;
            cpu_vram_rvalid <= cpu_vram_gnt & ~cpu_vram_we;
        end
    end

endmodule

// File: src/vram_sp.sv
`timescale 1ns/1ps

module vram_sp import vdp_pkg::*; (
    input  logic               cpu_bus,
    input  logic [vram_aw-1:0] addr,
    input  logic               we,
    input  logic [7:0]         wdata,
    output logic [7:0]         q
);

    logic [7:0] mem [0:vram_words-1];

    always_ff @(posedge cpu_bus) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr]; // Old data on a write cycle
    end

endmodule
